/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= uart_io_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/uart_io_pkg.sv */
`default_nettype none

package uart_io_pkg;

	// word addresses on the I/O bus, byte address bits [15:2]
	localparam logic [13:0] ADR_OUTC = 14'h3F00;
	localparam logic [13:0] ADR_FULL = 14'h3F01;
	localparam logic [13:0] ADR_TERM = 14'h3F02;
	localparam logic [13:0] ADR_RXCH = 14'h3F03;

	// divisor reset values, one per init_uart setting
	// 100 MHz clock at 921600 bps
	localparam logic [15:0] TERM_RESET_0 = 16'd109;
	// 50 MHz clock at 921600 bps
	localparam logic [15:0] TERM_RESET_1 = 16'd54;
	// 50 MHz clock at 9600 bps
	localparam logic [15:0] TERM_RESET_2 = 16'd5208;
	// 48 MHz clock at 9600 bps
	localparam logic [15:0] TERM_RESET_3 = 16'd5000;

	// transmit FIFO depth unless the top level overrides it
	localparam int FIFO_DEPTH_DEFAULT = 4;

	// transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	// receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

`default_nettype wire

/* design/uart_io_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_io_regs (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        io_we,
	input  logic [15:2] io_wadr,
	input  logic [31:0] io_wdata,
	input  logic        io_radr_en,
	input  logic [15:2] io_radr,
	input  logic [31:0] io_rdata_in,
	output logic [31:0] io_rdata,
	output logic [7:0]  uart_io_char,
	output logic        uart_io_we,
	input  logic        uart_io_full,
	input  logic [1:0]  init_uart,
	output logic [15:0] uart_term,
	input  logic        cpu_run_state,
	input  logic        rout_en,
	input  logic [7:0]  rout,
	output logic        ext_uart_interrupt
);

	logic        we_char;
	logic        we_term;
	logic        re_char;
	logic        re_full;
	logic        re_term;
	logic        re_rxch;
	logic        rx_accept;
	logic [15:0] term_reset;
	logic [7:0]  rx_latch;
	logic        rx_poll;
	logic        rx_overrun;
	// one-hot: rxch, term, full, char
	logic [3:0]  rd_sel;

	// address decode
	assign we_char = io_we && (io_wadr == uart_io_pkg::ADR_OUTC);
	assign we_term = io_we && (io_wadr == uart_io_pkg::ADR_TERM);
	assign re_char = io_radr_en && (io_radr == uart_io_pkg::ADR_OUTC);
	assign re_full = io_radr_en && (io_radr == uart_io_pkg::ADR_FULL);
	assign re_term = io_radr_en && (io_radr == uart_io_pkg::ADR_TERM);
	assign re_rxch = io_radr_en && (io_radr == uart_io_pkg::ADR_RXCH);

	// a received byte only counts while the CPU runs
	assign rx_accept = cpu_run_state && rout_en;
	assign ext_uart_interrupt = rx_accept;

	always_comb begin
		case (init_uart)
			2'd0:    term_reset = uart_io_pkg::TERM_RESET_0;
			2'd1:    term_reset = uart_io_pkg::TERM_RESET_1;
			2'd2:    term_reset = uart_io_pkg::TERM_RESET_2;
			default: term_reset = uart_io_pkg::TERM_RESET_3;
		endcase
	end

	// character register, writes dropped while the FIFO is full
	always_ff @(posedge clk) begin
		if (we_char && !uart_io_full) begin
			uart_io_char <= io_wdata[7:0];
		end
	end

	// push strobe lines up with the new character
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uart_io_we <= 1'b0;
		end else begin
			uart_io_we <= we_char && !uart_io_full;
		end
	end

	// bit period in clocks
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uart_term <= term_reset;
		end else if (we_term) begin
			uart_term <= io_wdata[15:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_latch <= 8'd0;
		end else if (rx_accept) begin
			rx_latch <= rout;
		end
	end

	// flags clear at the end of the RXCH data cycle
	// a byte landing on that same edge keeps the polling bit set
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_poll    <= 1'b0;
			rx_overrun <= 1'b0;
		end else if (rd_sel[3]) begin
			rx_poll    <= rx_accept;
			rx_overrun <= 1'b0;
		end else if (rx_accept) begin
			rx_poll <= 1'b1;
			if (rx_poll) begin
				rx_overrun <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_sel <= 4'd0;
		end else begin
			rd_sel <= {re_rxch, re_term, re_full, re_char};
		end
	end

	// read data in the cycle after the strobe, else daisy chain
	always_comb begin
		if (rd_sel[0]) begin
			io_rdata = {24'd0, uart_io_char};
		end else if (rd_sel[1]) begin
			io_rdata = {31'd0, uart_io_full};
		end else if (rd_sel[2]) begin
			io_rdata = {16'd0, uart_term};
		end else if (rd_sel[3]) begin
			io_rdata = {22'd0, rx_overrun, rx_poll, rx_latch};
		end else begin
			io_rdata = io_rdata_in;
		end
	end

endmodule

`default_nettype wire

/* design/uart_io_top.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_io_top #(
	parameter int FIFO_DEPTH = uart_io_pkg::FIFO_DEPTH_DEFAULT
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        io_we,
	input  logic [15:2] io_wadr,
	input  logic [31:0] io_wdata,
	input  logic        io_radr_en,
	input  logic [15:2] io_radr,
	input  logic [31:0] io_rdata_in,
	output logic [31:0] io_rdata,
	output logic        txd,
	input  logic        rxd,
	input  logic        cpu_run_state,
	input  logic [1:0]  init_uart,
	output logic        ext_uart_interrupt
);

	logic [7:0]  uart_io_char;
	logic        uart_io_we;
	logic        uart_io_full;
	logic [15:0] uart_term;
	logic        tx_pop;
	logic [7:0]  tx_data;
	logic        tx_empty;
	logic [7:0]  rout;
	logic        rout_en;

	uart_io_regs u_regs (
		.clk                (clk),
		.rst_n              (rst_n),
		.io_we              (io_we),
		.io_wadr            (io_wadr),
		.io_wdata           (io_wdata),
		.io_radr_en         (io_radr_en),
		.io_radr            (io_radr),
		.io_rdata_in        (io_rdata_in),
		.io_rdata           (io_rdata),
		.uart_io_char       (uart_io_char),
		.uart_io_we         (uart_io_we),
		.uart_io_full       (uart_io_full),
		.init_uart          (init_uart),
		.uart_term          (uart_term),
		.cpu_run_state      (cpu_run_state),
		.rout_en            (rout_en),
		.rout               (rout),
		.ext_uart_interrupt (ext_uart_interrupt)
	);

	uart_tx_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (uart_io_we),
		.push_data (uart_io_char),
		.pop       (tx_pop),
		.pop_data  (tx_data),
		.full      (uart_io_full),
		.empty     (tx_empty)
	);

	uart_tx u_tx (
		.clk      (clk),
		.rst_n    (rst_n),
		.term     (uart_term),
		.tx_data  (tx_data),
		.tx_empty (tx_empty),
		.tx_pop   (tx_pop),
		.txd      (txd)
	);

	uart_rx u_rx (
		.clk     (clk),
		.rst_n   (rst_n),
		.term    (uart_term),
		.rxd     (rxd),
		.rout    (rout),
		.rout_en (rout_en)
	);

endmodule

`default_nettype wire

/* design/uart_rx.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] term,
	input  logic        rxd,
	output logic [7:0]  rout,
	output logic        rout_en
);

	uart_io_pkg::rx_state_t state;

	logic        rxd_meta;
	logic        rxd_sync;
	logic        rxd_prev;
	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [15:0] half;
	logic        half_end;
	logic        period_end;

	assign half       = {1'b0, term[15:1]};
	assign half_end   = (cnt == half - 16'd1);
	assign period_end = (cnt == term - 16'd1);

	// line idles high
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	// data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (state == uart_io_pkg::RX_DATA && period_end) begin
			rout <= {rxd_sync, rout[7:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= uart_io_pkg::RX_IDLE;
			cnt     <= 16'd0;
			bit_idx <= 3'd0;
			rout_en <= 1'b0;
		end else begin
			rout_en <= 1'b0;
			cnt     <= cnt + 16'd1;
			case (state)
				uart_io_pkg::RX_IDLE: begin
					cnt <= 16'd0;
					if (rxd_prev && !rxd_sync) begin
						state <= uart_io_pkg::RX_START;
					end
				end
				uart_io_pkg::RX_START: begin
					// recheck mid start bit, glitches go back to idle
					if (half_end) begin
						cnt     <= 16'd0;
						bit_idx <= 3'd0;
						state   <= rxd_sync ? uart_io_pkg::RX_IDLE : uart_io_pkg::RX_DATA;
					end
				end
				uart_io_pkg::RX_DATA: begin
					if (period_end) begin
						cnt     <= 16'd0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= uart_io_pkg::RX_STOP;
						end
					end
				end
				default: begin
					if (period_end) begin
						// framing error drops the byte
						rout_en <= rxd_sync;
						state   <= uart_io_pkg::RX_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/uart_tx.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [15:0] term,
	input  logic [7:0]  tx_data,
	input  logic        tx_empty,
	output logic        tx_pop,
	output logic        txd
);

	uart_io_pkg::tx_state_t state;

	logic [15:0] cnt;
	logic [2:0]  bit_idx;
	logic [7:0]  shift;
	logic        period_end;
	logic        start_frame;

	// new byte only from idle
	assign start_frame = (state == uart_io_pkg::TX_IDLE) && !tx_empty;
	assign tx_pop      = start_frame;
	assign period_end  = (cnt == term - 16'd1);

	always_ff @(posedge clk) begin
		if (start_frame) begin
			shift <= tx_data;
		end else if (state == uart_io_pkg::TX_DATA && period_end) begin
			shift <= {1'b0, shift[7:1]};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= uart_io_pkg::TX_IDLE;
			cnt     <= 16'd0;
			bit_idx <= 3'd0;
			txd     <= 1'b1;
		end else begin
			cnt <= period_end ? 16'd0 : cnt + 16'd1;
			case (state)
				uart_io_pkg::TX_IDLE: begin
					cnt <= 16'd0;
					txd <= 1'b1;
					if (start_frame) begin
						state <= uart_io_pkg::TX_START;
						txd   <= 1'b0;
					end
				end
				uart_io_pkg::TX_START: begin
					if (period_end) begin
						state   <= uart_io_pkg::TX_DATA;
						bit_idx <= 3'd0;
						txd     <= shift[0];
					end
				end
				uart_io_pkg::TX_DATA: begin
					if (period_end) begin
						if (bit_idx == 3'd7) begin
							state <= uart_io_pkg::TX_STOP;
							txd   <= 1'b1;
						end else begin
							bit_idx <= bit_idx + 3'd1;
							// next bit before the shift lands
							txd     <= shift[1];
						end
					end
				end
				default: begin
					txd <= 1'b1;
					if (period_end) begin
						state <= uart_io_pkg::TX_IDLE;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/uart_tx_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_tx_fifo #(
	parameter int DEPTH = 4
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       push,
	input  logic [7:0] push_data,
	input  logic       pop,
	output logic [7:0] pop_data,
	output logic       full,
	output logic       empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [7:0]       mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);
	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* list.f */
design/uart_io_pkg.sv
design/uart_tx_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_io_regs.sv
design/uart_io_top.sv
tb/uart_io_props.sv
tb/uart_io_tb.sv

/* tb/uart_io_props.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_io_props (
	input logic                   clk,
	input logic                   rst_n,
	input logic                   io_we,
	input logic [15:2]            io_wadr,
	input logic                   uart_io_full,
	input logic                   uart_io_we,
	input logic                   cpu_run_state,
	input logic                   ext_uart_interrupt,
	input logic                   txd,
	input uart_io_pkg::tx_state_t tx_state
);

	bit drop_fail;
	bit gate_fail;
	bit pulse_fail;
	bit idle_fail;

	// back-pressure on the character register
	a_full_drop: assert property (@(posedge clk) disable iff (!rst_n)
		(io_we && io_wadr == uart_io_pkg::ADR_OUTC && uart_io_full) |=> !uart_io_we)
		else begin
			$error("character pushed although the FIFO was full at the write");
			drop_fail = 1'b1;
		end

	a_irq_gate: assert property (@(posedge clk) disable iff (!rst_n)
		ext_uart_interrupt |-> cpu_run_state)
		else begin
			$error("interrupt raised while the CPU run state was low");
			gate_fail = 1'b1;
		end

	a_irq_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		ext_uart_interrupt |=> !ext_uart_interrupt)
		else begin
			$error("interrupt lasted longer than one cycle");
			pulse_fail = 1'b1;
		end

	// line stays at mark level between frames
	a_txd_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(tx_state == uart_io_pkg::TX_IDLE) |-> txd)
		else begin
			$error("txd low while the transmitter was idle");
			idle_fail = 1'b1;
		end

endmodule

bind uart_io_top uart_io_props u_props (
	.clk                (clk),
	.rst_n              (rst_n),
	.io_we              (io_we),
	.io_wadr            (io_wadr),
	.uart_io_full       (uart_io_full),
	.uart_io_we         (uart_io_we),
	.cpu_run_state      (cpu_run_state),
	.ext_uart_interrupt (ext_uart_interrupt),
	.txd                (txd),
	.tx_state           (u_tx.state)
);

`default_nettype wire

/* tb/uart_io_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module uart_io_tb;

	localparam int FRAME_TERM = 16;
	// 20 frames of 10 bit periods, plus room for resets and bus traffic
	localparam int TIMEOUT_CYCLES = 20 * 10 * FRAME_TERM + 1000;
	localparam logic [13:0] ADR_UNMAPPED = 14'h3F04;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        io_we;
	logic [15:2] io_wadr;
	logic [31:0] io_wdata;
	logic        io_radr_en;
	logic [15:2] io_radr;
	logic [31:0] io_rdata_in;
	logic [31:0] io_rdata;
	logic        txd;
	logic        rxd;
	logic        cpu_run_state;
	logic [1:0]  init_uart;
	logic        ext_uart_interrupt;
	logic        use_frame;
	logic        frame_line;
	logic [31:0] lfsr_state = 32'h9dbd9d36;
	int          irq_count = 0;
	int          cycle_count = 0;

	uart_io_top #(
		.FIFO_DEPTH (4)
	) dut (
		.clk                (clk),
		.rst_n              (rst_n),
		.io_we              (io_we),
		.io_wadr            (io_wadr),
		.io_wdata           (io_wdata),
		.io_radr_en         (io_radr_en),
		.io_radr            (io_radr),
		.io_rdata_in        (io_rdata_in),
		.io_rdata           (io_rdata),
		.txd                (txd),
		.rxd                (rxd),
		.cpu_run_state      (cpu_run_state),
		.init_uart          (init_uart),
		.ext_uart_interrupt (ext_uart_interrupt)
	);

	// loopback unless a frame is driven from here
	assign rxd = use_frame ? frame_line : txd;

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks failed");
			$fatal(1);
		end
	end

	always @(negedge clk) begin
		if (rst_n && ext_uart_interrupt) begin
			irq_count <= irq_count + 1;
		end
	end

	// bound protocol checker, stop at its first failure
	always @(negedge clk) begin
		if (dut.u_props.drop_fail || dut.u_props.gate_fail ||
			dut.u_props.pulse_fail || dut.u_props.idle_fail) begin
			$display("a protocol assertion failed during the run");
			$display("Checks failed");
			$fatal(1);
		end
	end

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic take_random(input int nbits, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = galois_step(lfsr_state);
			value[i] = lfsr_state[0];
		end
	endtask

	// overrun at bit 9, polling at bit 8
	function automatic logic [31:0] rxch_word(input logic ovr, input logic poll,
		input logic [7:0] data);
		return {22'd0, ovr, poll, data};
	endfunction

	function automatic logic [31:0] term_reset(input logic [1:0] sel);
		case (sel)
			2'd0:    return {16'd0, uart_io_pkg::TERM_RESET_0};
			2'd1:    return {16'd0, uart_io_pkg::TERM_RESET_1};
			2'd2:    return {16'd0, uart_io_pkg::TERM_RESET_2};
			default: return {16'd0, uart_io_pkg::TERM_RESET_3};
		endcase
	endfunction

	task automatic report_error(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else report_error(test, expected, actual);
	endtask

	task automatic apply_reset(input logic [1:0] sel);
		@(posedge clk);
		rst_n     <= 1'b0;
		init_uart <= sel;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic bus_write(input logic [13:0] adr, input logic [31:0] data);
		@(posedge clk);
		io_we    <= 1'b1;
		io_wadr  <= adr;
		io_wdata <= data;
		@(posedge clk);
		io_we <= 1'b0;
	endtask

	// data cycle follows the strobe cycle
	task automatic check_read(input string test, input logic [13:0] adr,
		input logic [31:0] expected);
		@(posedge clk);
		io_radr_en <= 1'b1;
		io_radr    <= adr;
		@(posedge clk);
		io_radr_en <= 1'b0;
		@(negedge clk);
		check_equal(test, expected, io_rdata);
	endtask

	task automatic wait_irq();
		@(negedge clk);
		while (!ext_uart_interrupt) begin
			@(negedge clk);
		end
	endtask

	// 8N1 at the test divisor, LSB first
	task automatic send_frame(input logic [7:0] data);
		logic [9:0] bits;
		bits = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			frame_line <= bits[i];
			repeat (FRAME_TERM - 1) @(posedge clk);
		end
	endtask

	initial begin
		logic [31:0] rnd;
		logic [7:0]  first;
		logic [7:0]  second;
		int          irq_before;

		rst_n         = 1'b0;
		io_we         = 1'b0;
		io_wadr       = '0;
		io_wdata      = '0;
		io_radr_en    = 1'b0;
		io_radr       = '0;
		io_rdata_in   = '0;
		cpu_run_state = 1'b0;
		init_uart     = 2'd0;
		use_frame     = 1'b1;
		frame_line    = 1'b1;

		// divisor reset table
		for (int pass = 0; pass < 2; pass++) begin
			for (int sel = 0; sel < 4; sel++) begin
				apply_reset(2'(sel));
				check_read("term_reset", uart_io_pkg::ADR_TERM, term_reset(2'(sel)));
			end
		end

		bus_write(uart_io_pkg::ADR_TERM, 32'(FRAME_TERM));
		check_read("term_write", uart_io_pkg::ADR_TERM, 32'(FRAME_TERM));
		take_random(32, rnd);
		@(posedge clk);
		io_rdata_in <= rnd;
		check_read("pass_through", ADR_UNMAPPED, rnd);
		@(posedge clk);
		use_frame     <= 1'b0;
		cpu_run_state <= 1'b1;

		// single byte through the loopback
		take_random(8, rnd);
		first = rnd[7:0];
		irq_before = irq_count;
		bus_write(uart_io_pkg::ADR_OUTC, {24'd0, first});
		wait_irq();
		check_read("loopback_byte", uart_io_pkg::ADR_RXCH, rxch_word(1'b0, 1'b1, first));
		check_read("loopback_clear", uart_io_pkg::ADR_RXCH, rxch_word(1'b0, 1'b0, first));
		check_equal("loopback_irq", irq_before + 1, irq_count);

		// two bytes, no read between them
		take_random(8, rnd);
		first = rnd[7:0];
		take_random(8, rnd);
		second = rnd[7:0];
		bus_write(uart_io_pkg::ADR_OUTC, {24'd0, first});
		bus_write(uart_io_pkg::ADR_OUTC, {24'd0, second});
		wait_irq();
		wait_irq();
		check_read("overrun", uart_io_pkg::ADR_RXCH, rxch_word(1'b1, 1'b1, second));

		// frame while the CPU is halted
		irq_before = irq_count;
		take_random(8, rnd);
		@(posedge clk);
		cpu_run_state <= 1'b0;
		use_frame     <= 1'b1;
		send_frame(rnd[7:0]);
		repeat (FRAME_TERM) @(posedge clk);
		check_equal("run_gate_irq", irq_before, irq_count);
		check_read("run_gate_latch", uart_io_pkg::ADR_RXCH, rxch_word(1'b0, 1'b0, second));
		@(posedge clk);
		use_frame     <= 1'b0;
		cpu_run_state <= 1'b1;

		// fill the FIFO behind the frame in flight
		for (int i = 0; i < 5; i++) begin
			take_random(8, rnd);
			second = rnd[7:0];
			bus_write(uart_io_pkg::ADR_OUTC, {24'd0, second});
		end
		check_read("full_set", uart_io_pkg::ADR_FULL, 32'd1);
		take_random(8, rnd);
		bus_write(uart_io_pkg::ADR_OUTC, {24'd0, rnd[7:0]});
		repeat (5) wait_irq();
		check_read("full_clear", uart_io_pkg::ADR_FULL, 32'd0);
		check_read("drain_last", uart_io_pkg::ADR_RXCH, rxch_word(1'b1, 1'b1, second));

		if (dut.u_props.drop_fail || dut.u_props.gate_fail ||
			dut.u_props.pulse_fail || dut.u_props.idle_fail) begin
			$display("a protocol assertion failed during the run");
			$display("Checks failed");
			$fatal(1);
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

`default_nettype wire
